// ==== logic/routerPkg.sv ====
`default_nettype none

package routerPkg;

  // five inputs of the mesh router
  localparam int NUM_PORTS = 5;

  // width of a port index
  localparam int PORT_W_BITS = 3;

  localparam logic [PORT_W_BITS-1:0] PORT_L = 3'd0; // local
  localparam logic [PORT_W_BITS-1:0] PORT_N = 3'd1;
  localparam logic [PORT_W_BITS-1:0] PORT_E = 3'd2;
  localparam logic [PORT_W_BITS-1:0] PORT_W = 3'd3;
  localparam logic [PORT_W_BITS-1:0] PORT_S = 3'd4;

  // flit id codes, one-hot
  localparam int FLIT_ID_W = 3;

  localparam logic [FLIT_ID_W-1:0] ID_HEAD = 3'b001;
  localparam logic [FLIT_ID_W-1:0] ID_BODY = 3'b010;
  localparam logic [FLIT_ID_W-1:0] ID_TAIL = 3'b100;

  // packet length in the low bits of the header data word,
  // counted in flits with the header included
  localparam int LEN_W = 12;

endpackage

`default_nettype wire

// ==== logic/flitFifo.sv ====
`default_nettype none

module flitFifo #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            inValid,
  input  logic [routerPkg::FLIT_ID_W-1:0] inId,
  input  logic [DATA_W-1:0]               inData,
  input  logic                            take,
  output logic                            inReady,
  output logic                            headValid,
  output logic [routerPkg::FLIT_ID_W-1:0] headId,
  output logic [DATA_W-1:0]               headData
);
  import routerPkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  logic [FLIT_ID_W-1:0] idMem [DEPTH];
  logic [DATA_W-1:0]    dataMem [DEPTH];
  logic [ADDR_W-1:0]    wrPtr;
  logic [ADDR_W-1:0]    rdPtr;
  logic [ADDR_W:0]      count;
  logic                 push;

  assign inReady   = count != (ADDR_W + 1)'(DEPTH);
  assign headValid = count != '0;
  assign headId    = idMem[rdPtr];
  assign headData  = dataMem[rdPtr];
  assign push      = inValid && inReady;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr]   <= inId;
      dataMem[wrPtr] <= inData;
    end
  end

  // pointers wrap by themselves, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (take)
        rdPtr <= rdPtr + 1'b1;
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // both or neither
      endcase
    end
  end

  // the mux must only pop a port that has a flit waiting
  assert property (@(posedge clk) disable iff (rst) take |-> headValid);

endmodule

`default_nettype wire

// ==== logic/packetTimer.sv ====
`default_nettype none

module packetTimer #(
  parameter int DATA_W = 16
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            take,
  input  logic [routerPkg::FLIT_ID_W-1:0] headId,
  input  logic [DATA_W-1:0]               headData,
  output logic                            lastFlit
);
  import routerPkg::*;

  logic [LEN_W-1:0] pktLen;
  logic [LEN_W-1:0] flitCount;
  logic [LEN_W-1:0] nextCount;
  logic [LEN_W-1:0] headLen;
  logic             isHead;

  assign isHead  = headId == ID_HEAD;
  assign headLen = headData[LEN_W-1:0];

  // a header restarts the count at one
  assign nextCount = isHead ? LEN_W'(1) : flitCount + 1'b1;

  // length comes from the header itself when the header is the flit taken now
  assign lastFlit = take && (nextCount == (isHead ? headLen : pktLen));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen    <= '0;
      flitCount <= '0;
    end
    else if (take)
    begin
      flitCount <= nextCount;
      if (isHead)
        pktLen <= headLen;
    end
  end

  // zero length would hold the output forever
  assert property (@(posedge clk) disable iff (rst) (take && isHead) |-> headLen != '0);

endmodule

`default_nettype wire

// ==== logic/outputArbiter.sv ====
`default_nettype none

module outputArbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [routerPkg::NUM_PORTS-1:0] req,
  input  logic [routerPkg::NUM_PORTS-1:0] lastFlit,
  output logic [routerPkg::NUM_PORTS-1:0] grant
);
  import routerPkg::*;

  typedef enum logic {
    IDLE,
    LOCKED
  } arbState;

  arbState                state;
  arbState                stateNext;
  logic [NUM_PORTS-1:0]   grantNext;
  logic [PORT_W_BITS-1:0] lastServed;
  logic [PORT_W_BITS-1:0] lastServedNext;
  logic [NUM_PORTS-1:0]   reqEff;
  logic                   packetDone;
  logic                   pickValid;
  logic [PORT_W_BITS-1:0] pickIdx;

  assign packetDone = |(lastFlit & grant);

  // a port sending its final flit now drops out of this pick
  assign reqEff = req & ~lastFlit;

  // round robin scan, starting one past the last served port
  always_comb
  begin
    int cand;
    pickValid = 1'b0;
    pickIdx   = lastServed;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      cand = (int'(lastServed) + i) % NUM_PORTS;
      if (!pickValid && reqEff[cand])
      begin
        pickValid = 1'b1;
        pickIdx   = PORT_W_BITS'(cand);
      end
    end
  end

  always_comb
  begin
    stateNext      = state;
    grantNext      = grant;
    lastServedNext = lastServed;
    case (state)
      IDLE:
      begin
        if (pickValid)
        begin
          stateNext      = LOCKED;
          grantNext      = NUM_PORTS'(1) << pickIdx;
          lastServedNext = pickIdx;
        end
      end
      LOCKED:
      begin
        // held until the packet's last flit leaves, even when req drops
        if (packetDone)
        begin
          if (pickValid)
          begin
            grantNext      = NUM_PORTS'(1) << pickIdx;
            lastServedNext = pickIdx;
          end
          else
          begin
            stateNext = IDLE;
            grantNext = '0;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= IDLE;
      grant      <= '0;
      lastServed <= PORT_S; // first scan then starts at PORT_L
    end
    else
    begin
      state      <= stateNext;
      grant      <= grantNext;
      lastServed <= lastServedNext;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

`default_nettype wire

// ==== logic/outputMux.sv ====
`default_nettype none

module outputMux #(
  parameter int DATA_W = 16
) (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [routerPkg::NUM_PORTS-1:0]                        grant,
  input  logic [routerPkg::NUM_PORTS-1:0]                        headValid,
  input  logic [routerPkg::NUM_PORTS-1:0][routerPkg::FLIT_ID_W-1:0] headId,
  input  logic [routerPkg::NUM_PORTS-1:0][DATA_W-1:0]            headData,
  input  logic                                                   outReady,
  output logic [routerPkg::NUM_PORTS-1:0]                        take,
  output logic                                                   outValid,
  output logic [routerPkg::FLIT_ID_W-1:0]                        outId,
  output logic [DATA_W-1:0]                                      outData,
  output logic [routerPkg::PORT_W_BITS-1:0]                      outPort
);
  import routerPkg::*;

  logic [FLIT_ID_W-1:0]   selId;
  logic [DATA_W-1:0]      selData;
  logic [PORT_W_BITS-1:0] selPort;
  logic                   canLoad;

  // grant is one-hot so at most one port matches
  always_comb
  begin
    selId   = '0;
    selData = '0;
    selPort = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        selId   = headId[p];
        selData = headData[p];
        selPort = PORT_W_BITS'(p);
      end
    end
  end

  assign canLoad = !outValid || outReady; // register empty or draining
  assign take    = grant & headValid & {NUM_PORTS{canLoad}};

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (canLoad)
      outValid <= |take;
  end

  always_ff @(posedge clk)
  begin
    if (|take)
    begin
      outId   <= selId;
      outData <= selData;
      outPort <= selPort;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=>
      (outValid && $stable(outId) && $stable(outData) && $stable(outPort)));

endmodule

`default_nettype wire

// ==== logic/routerOutput.sv ====
`default_nettype none

module routerOutput #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [routerPkg::NUM_PORTS-1:0]                        inValid,
  input  logic [routerPkg::NUM_PORTS-1:0][routerPkg::FLIT_ID_W-1:0] inId,
  input  logic [routerPkg::NUM_PORTS-1:0][DATA_W-1:0]            inData,
  input  logic                                                   outReady,
  output logic [routerPkg::NUM_PORTS-1:0]                        inReady,
  output logic                                                   outValid,
  output logic [routerPkg::FLIT_ID_W-1:0]                        outId,
  output logic [DATA_W-1:0]                                      outData,
  output logic [routerPkg::PORT_W_BITS-1:0]                      outPort
);
  import routerPkg::*;

  logic [NUM_PORTS-1:0]                headValid;
  logic [NUM_PORTS-1:0][FLIT_ID_W-1:0] headId;
  logic [NUM_PORTS-1:0][DATA_W-1:0]    headData;
  logic [NUM_PORTS-1:0]                take;
  logic [NUM_PORTS-1:0]                lastFlit;
  logic [NUM_PORTS-1:0]                grant;

  // one buffer and one length tracker per input
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gPort
    flitFifo #(
      .DATA_W(DATA_W),
      .DEPTH (DEPTH)
    ) i_fifo (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inId     (inId[p]),
      .inData   (inData[p]),
      .take     (take[p]),
      .inReady  (inReady[p]),
      .headValid(headValid[p]),
      .headId   (headId[p]),
      .headData (headData[p])
    );

    packetTimer #(
      .DATA_W(DATA_W)
    ) i_timer (
      .clk     (clk),
      .rst     (rst),
      .take    (take[p]),
      .headId  (headId[p]),
      .headData(headData[p]),
      .lastFlit(lastFlit[p])
    );
  end

  outputArbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .req     (headValid), // a waiting flit is a request
    .lastFlit(lastFlit),
    .grant   (grant)
  );

  outputMux #(
    .DATA_W(DATA_W)
  ) i_mux (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .headValid(headValid),
    .headId   (headId),
    .headData (headData),
    .outReady (outReady),
    .take     (take),
    .outValid (outValid),
    .outId    (outId),
    .outData  (outData),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

// ==== bench/routerOutputTb.sv ====
`default_nettype none

module routerOutputTb;
  import routerPkg::*;

  localparam int DATA_W     = 16;
  localparam int DEPTH      = 4;
  localparam int NUM_PKTS   = 22;
  localparam int NUM_GROUPS = 11;
  localparam int FLIT_W     = FLIT_ID_W + DATA_W;

  // bit offsets of the table fields
  localparam int F_TEST  = 28;
  localparam int F_PORT  = 24;
  localparam int F_LEN   = 16;
  localparam int F_SEED  = 8;
  localparam int F_GROUP = 4;

  // test | port | length | seed | group | flags
  // flags: bit 0 gaps between flits, bit 1 outReady held low while loading, bit 2 random outReady
  localparam logic [31:0] PKT_TABLE [NUM_PKTS] = '{
    32'h1_0_01_11_0_0, 32'h1_1_02_12_1_0, 32'h1_2_05_13_2_0, 32'h1_3_01_14_3_0,
    32'h1_4_02_15_4_0,
    32'h2_0_03_21_5_2, 32'h2_1_02_22_5_2, 32'h2_2_04_23_5_2, 32'h2_3_01_24_5_2,
    32'h2_4_03_25_5_2,
    32'h3_2_02_31_6_0, 32'h3_0_03_32_6_0, 32'h3_1_02_33_7_0, 32'h3_1_03_34_8_0,
    32'h3_3_02_35_8_0,
    32'h4_2_06_41_9_1, 32'h4_4_03_42_9_0,
    32'h5_0_0c_51_a_4, 32'h5_1_09_52_a_4, 32'h5_2_0e_53_a_4, 32'h5_3_07_54_a_4,
    32'h5_4_0b_55_a_4
  };

  logic                                clk      = 1'b0;
  logic                                rst      = 1'b1;
  logic [NUM_PORTS-1:0]                inValid  = '0;
  logic [NUM_PORTS-1:0][FLIT_ID_W-1:0] inId     = '0;
  logic [NUM_PORTS-1:0][DATA_W-1:0]    inData   = '0;
  logic                                outReady = 1'b0;
  logic [NUM_PORTS-1:0]                inReady;
  logic                                outValid;
  logic [FLIT_ID_W-1:0]                outId;
  logic [DATA_W-1:0]                   outData;
  logic [PORT_W_BITS-1:0]              outPort;

  logic [FLIT_W-1:0]             txMem [NUM_PORTS][64];
  int                            txHead [NUM_PORTS];
  int                            txTail [NUM_PORTS];
  int                            gap [NUM_PORTS];
  logic [NUM_PORTS-1:0]          gapped      = '0;
  logic [PORT_W_BITS+FLIT_W-1:0] expMem [256];
  int                            expHead     = 0;
  int                            expTail     = 0;
  int                            modelLast   = int'(PORT_S); // first pick lands on PORT_L
  int                            flitErrors  = 0;
  logic [31:0]                   lfsr        = 32'hffe3_6bf5;
  logic                          holdLow     = 1'b0;
  logic                          randomReady = 1'b0;
  logic                          sawFull     = 1'b0;

  routerOutput #(
    .DATA_W(DATA_W),
    .DEPTH (DEPTH)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inId    (inId),
    .inData  (inData),
    .outReady(outReady),
    .inReady (inReady),
    .outValid(outValid),
    .outId   (outId),
    .outData (outData),
    .outPort (outPort)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  function automatic int drawBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int tableField(input int i, input int lo, input int bits);
    return int'((PKT_TABLE[i] >> lo) & ((32'd1 << bits) - 32'd1));
  endfunction

  function automatic int groupTest(input int g);
    for (int i = 0; i < NUM_PKTS; i++)
      if (tableField(i, F_GROUP, 4) == g)
        return tableField(i, F_TEST, 4);
    return 0;
  endfunction

  function automatic int totalFlits();
    int n;
    n = 0;
    for (int i = 0; i < NUM_PKTS; i++)
      n = n + tableField(i, F_LEN, 8);
    return n;
  endfunction

  // flit k of a packet, id and data word together
  function automatic logic [FLIT_W-1:0] makeFlit(input int len, input int seed, input int k);
    logic [FLIT_ID_W-1:0] id;
    logic [DATA_W-1:0]    data;
    if (k == 0)
      id = ID_HEAD;
    else if (k == len - 1)
      id = ID_TAIL;
    else
      id = ID_BODY;
    if (k == 0)
      data = DATA_W'(len) | DATA_W'(seed << LEN_W); // length in the low bits
    else
      data = DATA_W'(seed * 31 + k * 977);
    return {id, data};
  endfunction

  // loads one group into the port queues and appends the expected order
  task automatic launchGroup(input int g);
    int owner [NUM_PORTS];
    int p;
    int len;
    int seed;
    int last;
    holdLow     = 1'b0;
    randomReady = 1'b0;
    sawFull     = 1'b0;
    gapped      = '0;
    for (int q = 0; q < NUM_PORTS; q++)
      owner[q] = -1;
    for (int i = 0; i < NUM_PKTS; i++)
    begin
      if (tableField(i, F_GROUP, 4) == g)
      begin
        p           = tableField(i, F_PORT, 4);
        owner[p]    = i;
        gapped[p]   = PKT_TABLE[i][0];
        holdLow     = holdLow | PKT_TABLE[i][1];
        randomReady = randomReady | PKT_TABLE[i][2];
      end
    end
    last = modelLast;
    for (int k = 1; k <= NUM_PORTS; k++)
    begin
      p = (modelLast + k) % NUM_PORTS; // rotation, one past the last served port
      if (owner[p] >= 0)
      begin
        len  = tableField(owner[p], F_LEN, 8);
        seed = tableField(owner[p], F_SEED, 8);
        for (int j = 0; j < len; j++)
        begin
          txMem[p][txTail[p]] = makeFlit(len, seed, j);
          txTail[p]++;
          expMem[expTail] = {PORT_W_BITS'(p), makeFlit(len, seed, j)};
          expTail++;
        end
        last = p;
      end
    end
    modelLast = last;
  endtask

  function automatic logic allLoaded();
    for (int p = 0; p < NUM_PORTS; p++)
      if (txHead[p] != txTail[p])
        return 1'b0;
    return 1'b1;
  endfunction

  // port drivers and outReady
  always @(posedge clk)
  begin
    int nextIdx;
    if (randomReady)
      outReady <= drawBits(2) != 0;
    else
      outReady <= !holdLow;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      nextIdx = txHead[p];
      if (inValid[p] && inReady[p])
      begin
        nextIdx = nextIdx + 1;
        if (gapped[p])
          gap[p] = drawBits(2);
      end
      txHead[p] = nextIdx;
      if (gap[p] > 0)
      begin
        gap[p]     = gap[p] - 1;
        inValid[p] <= 1'b0;
      end
      else if (nextIdx != txTail[p])
      begin
        inValid[p]           <= 1'b1;
        {inId[p], inData[p]} <= txMem[p][nextIdx];
      end
      else
        inValid[p] <= 1'b0;
    end
  end

  always @(posedge clk)
  begin
    logic [PORT_W_BITS+FLIT_W-1:0] exp;
    if (!rst && outValid && outReady)
    begin
      if (expHead == expTail)
      begin
        $display("flit from port %0d arrived when none was expected", outPort);
        flitErrors = flitErrors + 1;
      end
      else
      begin
        exp     = expMem[expHead];
        expHead = expHead + 1;
        if (outPort != exp[FLIT_W +: PORT_W_BITS])
        begin
          $display("Mismatch outPort: got %h, expected %h", outPort, exp[FLIT_W +: PORT_W_BITS]);
          flitErrors = flitErrors + 1;
        end
        if (outId != exp[DATA_W +: FLIT_ID_W])
        begin
          $display("Mismatch outId: got %h, expected %h", outId, exp[DATA_W +: FLIT_ID_W]);
          flitErrors = flitErrors + 1;
        end
        if (outData != exp[DATA_W-1:0])
        begin
          $display("Mismatch outData: got %h, expected %h", outData, exp[DATA_W-1:0]);
          flitErrors = flitErrors + 1;
        end
      end
    end
  end

  initial
  begin
    int limit;
    int cycles;
    limit = 8 * totalFlits() + 200;
    for (cycles = 0; cycles < limit; cycles++)
      @(posedge clk);
    $display("timeout after %0d cycles, not every expected flit came out", limit);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    int tst;
    int localErr;
    int prevErrors;
    int testsRun;
    int testsFailed;
    localErr    = 0;
    prevErrors  = 0;
    testsRun    = 0;
    testsFailed = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (outValid !== 1'b0 || inReady !== '1)
    begin
      $display("outputs not idle after reset");
      localErr++;
    end
    for (int g = 0; g < NUM_GROUPS; g++)
    begin
      @(negedge clk);
      launchGroup(g);
      if (holdLow)
      begin
        while (!allLoaded())
          @(negedge clk);
        repeat (4) @(negedge clk); // output register stays full meanwhile
        holdLow = 1'b0;
      end
      while (!allLoaded() || expHead != expTail)
      begin
        @(negedge clk);
        if (inReady != '1)
          sawFull = 1'b1;
      end
      randomReady = 1'b0;
      if (g == NUM_GROUPS - 1 || groupTest(g + 1) != groupTest(g))
      begin
        tst = groupTest(g);
        if (tst == 5 && !sawFull)
        begin
          $display("inReady never dropped during the back-pressure test");
          localErr++;
        end
        localErr   = localErr + flitErrors - prevErrors;
        prevErrors = flitErrors;
        testsRun++;
        if (localErr == 0)
          $display("test %0d: ok", tst);
        else
        begin
          $display("test %0d: failed with %0d errors", tst, localErr);
          testsFailed++;
        end
        localErr = 0;
      end
    end
    $display("tests run %0d, failed %0d, flit errors %0d", testsRun, testsFailed, flitErrors);
    if (testsFailed == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/routerPkg.sv
logic/flitFifo.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/outputMux.sv
logic/routerOutput.sv
bench/routerOutputTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the router output testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module routerOutputTb --Mdir obj_dir -o routerOutputSim \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/routerOutputSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
